// ==== aesInvPkg.sv ====
package aesInvPkg;

    localparam int numRounds    = 10;
    localparam int keyWords     = 4;
    localparam int blockBits    = 128;
    localparam int numRoundKeys = numRounds + 1;

    typedef logic [7:0]  byteT;
    typedef logic [31:0] wordT;

    // Byte 0 sits in the top bits and the bytes run down each column in turn.
    typedef logic [blockBits-1:0] blockT;

    // Indexed by round number.
    typedef blockT [numRoundKeys-1:0] roundKeysT;

    typedef struct packed {
        logic  valid;
        blockT data;
    } stageT;

    // Low byte of x^8 + x^4 + x^3 + x + 1.
    localparam byteT gfPoly = 8'h1b;

    function automatic byteT xtime(byteT b);
        byteT shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ gfPoly;
        end
        return shifted;
    endfunction

    // Shift and add over the bits of b.
    function automatic byteT gfMul(byteT a, byteT b);
        byteT acc;
        byteT term;
        acc  = '0;
        term = a;
        for (int k = 0; k < 8; k++) begin
            if (b[k]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // Inverse as a^254, so zero maps to zero without a special case.
    function automatic byteT gfInv(byteT a);
        byteT sq;
        byteT acc;
        sq  = a;
        acc = 8'h01;
        for (int k = 1; k < 8; k++) begin
            sq  = gfMul(sq, sq);
            acc = gfMul(acc, sq);
        end
        return acc;
    endfunction

    function automatic byteT rotByte(byteT b, int n);
        byteT rotated;
        rotated = b;
        for (int k = 0; k < 8; k++) begin
            if (k < n) begin
                rotated = {rotated[6:0], rotated[7]};
            end
        end
        return rotated;
    endfunction

    // Affine map after the field inverse.
    function automatic byteT sbox(byteT b);
        byteT inv;
        inv = gfInv(b);
        return inv ^ rotByte(inv, 1) ^ rotByte(inv, 2) ^ rotByte(inv, 3)
                   ^ rotByte(inv, 4) ^ 8'h63;
    endfunction

    // Undo the affine map first, then invert.
    function automatic byteT invSbox(byteT b);
        byteT pre;
        pre = rotByte(b, 1) ^ rotByte(b, 3) ^ rotByte(b, 6) ^ 8'h05;
        return gfInv(pre);
    endfunction

    // Round constant for word index idx, a power of {02} in the top byte.
    function automatic wordT rcon(int idx);
        byteT rc;
        rc = 8'h01;
        for (int k = 1; k < numRounds; k++) begin
            if (k < idx / keyWords) begin
                rc = xtime(rc);
            end
        end
        return {rc, 24'h000000};
    endfunction

endpackage

// ==== aesKeyExpansion.sv ====
`timescale 1ns/1ps

module aesKeyExpansion (
    input  aesInvPkg::blockT     key,
    output aesInvPkg::roundKeysT roundKeys
);
    import aesInvPkg::*;

    function automatic wordT rotWord(wordT x);
        return {x[23:0], x[31:24]};
    endfunction

    function automatic wordT subWord(wordT x);
        return {sbox(x[31:24]), sbox(x[23:16]), sbox(x[15:8]), sbox(x[7:0])};
    endfunction

    // Each word builds on the words before it.
    always_comb begin
        wordT w [keyWords*numRoundKeys];
        wordT temp;

        for (int i = 0; i < keyWords; i++) begin
            w[i] = key[blockBits-1-32*i -: 32];
        end

        for (int i = keyWords; i < keyWords*numRoundKeys; i++) begin
            temp = w[i-1];
            if (i % keyWords == 0) begin
                temp = subWord(rotWord(temp)) ^ rcon(i);
            end
            w[i] = w[i-keyWords] ^ temp;
        end

        // Four consecutive words make one round key.
        for (int r = 0; r < numRoundKeys; r++) begin
            roundKeys[r] = {w[keyWords*r],     w[keyWords*r + 1],
                            w[keyWords*r + 2], w[keyWords*r + 3]};
        end
    end

endmodule

// ==== aesInvMixColumns.sv ====
`timescale 1ns/1ps

module aesInvMixColumns (
    input  aesInvPkg::blockT state,
    output aesInvPkg::blockT mixed
);
    import aesInvPkg::*;

    // One column times the circulant matrix {0e} {0b} {0d} {09}.
    function automatic wordT invMixColumn(wordT col);
        byteT a   [4];
        byteT x2  [4];
        byteT x4  [4];
        byteT x8  [4];
        byteT m9  [4];
        byteT mB  [4];
        byteT mD  [4];
        byteT mE  [4];
        byteT res [4];

        for (int k = 0; k < 4; k++) begin
            a[k]  = col[31-8*k -: 8];
            x2[k] = xtime(a[k]);
            x4[k] = xtime(x2[k]);
            x8[k] = xtime(x4[k]);
            m9[k] = x8[k] ^ a[k];
            mB[k] = x8[k] ^ x2[k] ^ a[k];
            mD[k] = x8[k] ^ x4[k] ^ a[k];
            mE[k] = x8[k] ^ x4[k] ^ x2[k];
        end

        // Each output row is the previous one rotated right by a byte.
        for (int k = 0; k < 4; k++) begin
            res[k] = mE[k] ^ mB[(k+1)%4] ^ mD[(k+2)%4] ^ m9[(k+3)%4];
        end
        return {res[0], res[1], res[2], res[3]};
    endfunction

    genvar c;
    generate
        for (c = 0; c < 4; c++) begin : g_column
            assign mixed[blockBits-1-32*c -: 32] = invMixColumn(state[blockBits-1-32*c -: 32]);
        end
    endgenerate

endmodule

// ==== aesInvRound.sv ====
`timescale 1ns/1ps

module aesInvRound #(
    parameter bit lastRound = 1'b0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  aesInvPkg::stageT stageIn,
    input  aesInvPkg::blockT roundKey,
    output aesInvPkg::stageT stageOut
);
    import aesInvPkg::*;

    blockT shifted;
    blockT subbed;
    blockT keyed;
    blockT nextData;

    // Row r rotates right by r bytes.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[blockBits-1-8*(4*c + r) -: 8] =
                    stageIn.data[blockBits-1-8*(4*((c - r + 4) % 4) + r) -: 8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            subbed[blockBits-1-8*i -: 8] = invSbox(shifted[blockBits-1-8*i -: 8]);
        end
    end

    assign keyed = subbed ^ roundKey;

    // Round 0 of the cipher has no InvMixColumns.
    generate
        if (!lastRound) begin : g_mix
            aesInvMixColumns u_invMixColumns (
                .state (keyed),
                .mixed (nextData)
            );
        end else begin : g_noMix
            assign nextData = keyed;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stageOut <= '0;
        end else begin
            stageOut.valid <= stageIn.valid;
            stageOut.data  <= nextData;
        end
    end

endmodule

// ==== aesInvCipher.sv ====
`timescale 1ns/1ps

module aesInvCipher (
    input  logic             clk,
    input  logic             rst_n,
    input  aesInvPkg::stageT cipherIn,
    input  aesInvPkg::blockT key,
    output aesInvPkg::stageT plainOut
);
    import aesInvPkg::*;

    roundKeysT roundKeys;
    stageT     initStage;
    stageT     roundOut [numRounds:1];

    // Key must hold steady while blocks are in flight.
    aesKeyExpansion u_keyExpansion (
        .key       (key),
        .roundKeys (roundKeys)
    );

    // First AddRoundKey uses the last round key.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            initStage <= '0;
        end else begin
            initStage.valid <= cipherIn.valid;
            initStage.data  <= cipherIn.data ^ roundKeys[numRounds];
        end
    end

    // Stage r uses round key r-1. Stage 1 is the final round.
    genvar r;
    generate
        for (r = numRounds; r >= 1; r = r - 1) begin : g_round
            stageT roundIn;

            if (r == numRounds) begin : g_first
                assign roundIn = initStage;
            end else begin : g_chain
                assign roundIn = roundOut[r+1];
            end

            aesInvRound #(
                .lastRound (r == 1)
            ) u_round (
                .clk      (clk),
                .rst_n    (rst_n),
                .stageIn  (roundIn),
                .roundKey (roundKeys[r-1]),
                .stageOut (roundOut[r])
            );
        end
    endgenerate

    // Output register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plainOut <= '0;
        end else begin
            plainOut <= roundOut[1];
        end
    end

endmodule

// ==== tbAesInvCipherVectors.svh ====
`ifndef TB_AES_INV_CIPHER_VECTORS_SVH
`define TB_AES_INV_CIPHER_VECTORS_SVH

// Columns are key, ciphertext, expected plaintext and idle cycles after the block.
// A gap of randGap is replaced by a random count at the start of the run.

typedef struct packed {
    blockT      key;
    blockT      cipher;
    blockT      plain;
    logic [7:0] gap;
} vectorT;

localparam logic [7:0] randGap = 8'hff;

// FIPS-197 Appendix C.1.
localparam blockT keyC1 = 128'h000102030405060708090a0b0c0d0e0f;
localparam blockT ctC1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam blockT ptC1  = 128'h00112233445566778899aabbccddeeff;

// FIPS-197 Appendix B.
localparam blockT keyB  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
localparam blockT ctB   = 128'h3925841d02dc09fbdc118597196a0b32;
localparam blockT ptB   = 128'h3243f6a8885a308d313198a2e0370734;

localparam int numVectors = 13;

vectorT vectors [numVectors] = '{
    '{keyC1, ctC1, ptC1, 8'd0},
    '{keyC1, ctC1, ptC1, 8'd0},
    '{keyC1, ctC1, ptC1, 8'd0},
    '{keyC1, ctC1, ptC1, randGap},
    '{keyC1, ctC1, ptC1, 8'd0},
    '{keyC1, ctC1, ptC1, randGap},
    '{keyB,  ctB,  ptB,  8'd0},
    '{keyB,  ctB,  ptB,  8'd0},
    '{keyB,  ctB,  ptB,  randGap},
    '{keyB,  ctB,  ptB,  8'd0},
    '{keyC1, ctC1, ptC1, randGap},
    '{keyC1, ctC1, ptC1, 8'd0},
    '{keyC1, ctC1, ptC1, 8'd3}
};

`endif

// ==== tbAesInvCipher.sv ====
`timescale 1ns/1ps

module tbAesInvCipher;
    import aesInvPkg::*;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 8;
    localparam int pipeLatency = 11;
    localparam int randSeed    = 97623;

    `include "tbAesInvCipherVectors.svh"

    typedef struct packed {
        blockT       plain;
        logic [31:0] dueCycle;
    } expectT;

    logic  clk = 1'b0;
    logic  rst_n;
    stageT cipherIn;
    blockT key;
    stageT plainOut;

    expectT expQ [$];
    int     gaps [numVectors];
    int     cycleCount    = 0;
    int     limitCycles   = 0;
    int     inCount       = 0;
    int     outCount      = 0;
    int     dataErrors    = 0;
    int     latencyErrors = 0;
    int     validErrors   = 0;

    aesInvCipher u_aesInvCipher (
        .clk      (clk),
        .rst_n    (rst_n),
        .cipherIn (cipherIn),
        .key      (key),
        .plainOut (plainOut)
    );

    always #(clkPeriod/2) clk = ~clk;

    // Number of rising edges seen so far.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic drawGaps();
        for (int i = 0; i < numVectors; i++) begin
            if (vectors[i].gap == randGap) begin
                gaps[i] = $urandom % 6;
            end else begin
                gaps[i] = vectors[i].gap;
            end
        end
    endtask

    function automatic int computeLimit();
        int total;
        int keyChanges;
        total      = 0;
        keyChanges = 0;
        for (int i = 0; i < numVectors; i++) begin
            total += gaps[i];
            if (i > 0 && vectors[i].key != vectors[i-1].key) begin
                keyChanges++;
            end
        end
        // Every key change and the final flush may each wait for a full drain.
        return resetCycles + total + numVectors + pipeLatency + 20
               + (keyChanges + 1) * (pipeLatency + 2);
    endfunction

    // Drives one block for a single cycle, called on a falling edge.
    task automatic applyBlock(input vectorT vec);
        expectT want;
        key            = vec.key;
        cipherIn.valid = 1'b1;
        cipherIn.data  = vec.cipher;
        want.plain     = vec.plain;
        want.dueCycle  = cycleCount + 1 + pipeLatency;
        expQ.push_back(want);
        inCount++;
        @(negedge clk);
        cipherIn = '0;
    endtask

    always @(negedge clk) begin
        expectT want;
        if (cycleCount >= 1 && cycleCount <= resetCycles + pipeLatency) begin
            if (plainOut.valid !== 1'b0) begin
                $display("ERR %0t: output valid not low at cycle %0d during reset or fill",
                         $time, cycleCount);
                validErrors++;
            end
        end else if (plainOut.valid === 1'b1) begin
            outCount++;
            if (expQ.size() == 0) begin
                $display("ERR %0t: output valid at cycle %0d with no block in flight",
                         $time, cycleCount);
                validErrors++;
            end else begin
                want = expQ.pop_front();
                if (plainOut.data !== want.plain) begin
                    $display("ERR %0t: plaintext %h, expected %h",
                             $time, plainOut.data, want.plain);
                    dataErrors++;
                end
                if (cycleCount != want.dueCycle) begin
                    $display("ERR %0t: block out at cycle %0d, expected cycle %0d",
                             $time, cycleCount, want.dueCycle);
                    latencyErrors++;
                end
            end
        end
    end

    initial begin
        wait (limitCycles != 0);
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: the run did not complete within %0d clock cycles", limitCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        cipherIn = '0;
        key      = '0;
        void'($urandom(randSeed));
        drawGaps();
        limitCycles = computeLimit();

        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < numVectors; i++) begin
            // Key is a level, so the pipeline empties before it moves.
            if (i > 0 && vectors[i].key != key) begin
                while (expQ.size() != 0) begin
                    @(negedge clk);
                end
            end
            applyBlock(vectors[i]);
            repeat (gaps[i]) @(negedge clk);
        end

        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        // Any stray valid would show up here.
        repeat (pipeLatency + 2) @(negedge clk);

        if (outCount != inCount) begin
            $display("ERR %0t: %0d blocks out, expected %0d", $time, outCount, inCount);
            validErrors++;
        end

        $display("Blocks in %0d, out %0d, data errors %0d, latency errors %0d, valid errors %0d",
                 inCount, outCount, dataErrors, latencyErrors, validErrors);
        if (dataErrors + latencyErrors + validErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
aesInvPkg.sv
aesKeyExpansion.sv
aesInvMixColumns.sv
aesInvRound.sv
aesInvCipher.sv
tbAesInvCipher.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tbAesInvCipher \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/VtbAesInvCipher > sim.log 2>&1
cat sim.log

grep -qx "SIMULATION PASSED" sim.log \
    && echo "Result: run passed" \
    || { echo "Result: run failed, see sim.log"; exit 1; }
